/* tb/programPatterns.txt */
# Columns: tag, hex byte address, hex word
# I = program word at that address, S = expected store address and data, in order
I 00 e2000000 # and r0, r0, #0
I 04 e2801005 # add r1, r0, #5
I 08 e281200c # add r2, r1, #12
I 0c e0423001 # sub r3, r2, r1
I 10 e5803000 # str r3, [r0, #0]
I 14 e2614064 # rsb r4, r1, #100
I 18 e5804004 # str r4, [r0, #4]
I 1c e202501c # and r5, r2, #0x1c
I 20 e0256002 # eor r6, r5, r2
I 24 e38670f0 # orr r7, r6, #0xf0
I 28 e5805008 # str r5, [r0, #8]
I 2c e580600c # str r6, [r0, #12]
I 30 e5807010 # str r7, [r0, #16]
I 34 e5908004 # ldr r8, [r0, #4]
I 38 e2889001 # add r9, r8, #1 right after the load
I 3c e5809014 # str r9, [r0, #20]
I 40 e590a000 # ldr r10, [r0, #0]
I 44 e580a018 # str r10, [r0, #24] right after the load
I 48 e3510005 # cmp r1, #5
I 4c 0280b022 # addeq r11, r0, #0x22
I 50 1280b033 # addne r11, r0, #0x33
I 54 e580b01c # str r11, [r0, #28]
I 58 e2a1c010 # adc r12, r1, #0x10 with carry set
I 5c e580c020 # str r12, [r0, #32]
I 60 e3170001 # tst r7, #1
I 64 1280d044 # addne r13, r0, #0x44
I 68 0280d055 # addeq r13, r0, #0x55
I 6c e3510006 # cmp r1, #6
I 70 328dd001 # addcc r13, r13, #1
I 74 228dd080 # addcs r13, r13, #0x80
I 78 e580d024 # str r13, [r0, #36]
I 7c e2a0e030 # adc r14, r0, #0x30 with carry clear
I 80 e580e028 # str r14, [r0, #40]
I 84 e3500000 # cmp r0, #0
I 88 1a000010 # bne 0xd0, falls through
I 8c e580102c # str r1, [r0, #44]
I 90 0a000001 # beq 0x9c, taken
I 94 e5802030 # str r2, [r0, #48] skipped
I 98 e5803034 # str r3, [r0, #52] skipped
I 9c e5804038 # str r4, [r0, #56]
I a0 e580903c # str r9, [r0, #60]
I a4 eafffffe # b 0xa4, end of program
S 00 0000000c # 17 - 5
S 04 0000005f # 100 - 5
S 08 00000010 # 0x11 and 0x1c
S 0c 00000001 # 0x10 eor 0x11
S 10 000000f1 # 0x01 orr 0xf0
S 14 00000060 # loaded 0x5f plus 1
S 18 0000000c # loaded word stored back
S 1c 00000022 # eq after equal compare
S 20 00000016 # 5 + 0x10 + carry
S 24 00000045 # ne after tst, then cc
S 28 00000030 # 0 + 0x30 + no carry
S 2c 00000005 # after the untaken branch
S 38 0000005f # branch target
S 3c 00000060

/* all.f */
logic/armPkg.sv
logic/alu.sv
logic/regFile.sv
logic/controller.sv
logic/hazardUnit.sv
logic/datapath.sv
logic/armPipe.sv
tb/armPipeTb.sv

/* Makefile */
# Verilator build and run of the pipelined ARM core testbench

VERILATOR ?= verilator
TOP       ?= armPipeTb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/armPipeTb.sv */
`timescale 1ns/100ps

module armPipeTb;

  localparam int clkPeriod    = 100;
  localparam int storeTimeout = 2000;
  localparam int idleCycles   = 10;

  logic           clk;
  logic           rstN;
  armPkg::wordT   pc;
  armPkg::wordT   instr;
  armPkg::memReqT memReq;
  armPkg::wordT   readData;

  armPkg::wordT imem [0:255];
  armPkg::wordT dmem [0:255];
  armPkg::wordT expAddr [$];
  armPkg::wordT expData [$];
  int           storeCount = 0;

  armPipe i_dut (
    .clk     (clk),
    .rstN    (rstN),
    .pc      (pc),
    .instr   (instr),
    .memReq  (memReq),
    .readData(readData)
  );

  // Both memories answer in the same cycle
  assign instr    = imem[pc[9:2]];
  assign readData = dmem[memReq.addr[9:2]];

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  task automatic stopRun();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkWord(string name, armPkg::wordT actual, armPkg::wordT expected);
    if (actual !== expected) begin
      $display("Fail %s: got %h, expected %h", name, actual, expected);
      stopRun();
    end
  endtask

  // Tag char first, then hex address and hex word; # starts a comment
  task automatic loadStimulusFile();
    int               fd;
    int               n;
    bit               done;
    logic [7:0]       tag;
    armPkg::wordT     addr;
    armPkg::wordT     word;
    logic [8*160-1:0] rest;
    fd = $fopen("tb/programPatterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file tb/programPatterns.txt");
      stopRun();
    end else begin
      done = 1'b0;
      while (!done) begin
        n = $fscanf(fd, " %c", tag);
        if (n != 1) begin
          done = 1'b1;
        end else if (tag == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h", addr, word);
          if (n != 2) begin
            $display("Pattern line with tag %c lacks its address or word", tag);
            stopRun();
          end else if (tag == "I") begin
            imem[addr[9:2]] = word;
          end else if (tag == "S") begin
            expAddr.push_back(addr);
            expData.push_back(word);
          end else begin
            $display("Unknown tag %c in the pattern file", tag);
            stopRun();
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Stores commit here and are checked in program order
  always @(posedge clk) begin
    if (memReq.write) begin
      if (!rstN) begin
        $display("A store appeared while reset was asserted");
        stopRun();
      end else if (storeCount >= expAddr.size()) begin
        $display("Store number %0d was not expected, the list holds %0d",
                 storeCount + 1, expAddr.size());
        stopRun();
      end else begin
        checkWord("memReq.addr", memReq.addr, expAddr[storeCount]);
        checkWord("memReq.writeData", memReq.writeData, expData[storeCount]);
        storeCount <= storeCount + 1;
      end
      dmem[memReq.addr[9:2]] <= memReq.writeData;
    end
  end

  initial begin
    int cycles;
    rstN = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = '0;
      dmem[i[7:0]] <= '0;
    end
    loadStimulusFile();
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    // First fetch of the released core
    @(negedge clk);
    checkWord("pc", pc, 32'h0);
    cycles = 0;
    while (storeCount < expAddr.size() && cycles < storeTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (storeCount < expAddr.size()) begin
      $display("Timed out after %0d cycles with %0d of %0d stores seen",
               cycles, storeCount, expAddr.size());
      stopRun();
    end else begin
      repeat (idleCycles) @(posedge clk);
      @(negedge clk);
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

/* logic/armPipe.sv */
`timescale 1ns/100ps

module armPipe (
  input  logic           clk,
  input  logic           rstN,
  output armPkg::wordT   pc,
  input  armPkg::wordT   instr,
  output armPkg::memReqT memReq,
  input  armPkg::wordT   readData
);

  armPkg::instrT      instrD;
  armPkg::flagsT      flagsE;
  logic               noWriteE;
  armPkg::decodeCtrlT decodeCtrl;
  armPkg::execCtrlT   execCtrl;
  logic               memWrite;
  armPkg::wbCtrlT     wbCtrl;
  armPkg::matchT      match;
  armPkg::ctrlStateT  ctrlState;
  armPkg::hazardT     hazard;

  datapath iDatapath (
    .clk       (clk),
    .rstN      (rstN),
    .pc        (pc),
    .instr     (instr),
    .instrD    (instrD),
    .decodeCtrl(decodeCtrl),
    .execCtrl  (execCtrl),
    .wbCtrl    (wbCtrl),
    .memWrite  (memWrite),
    .memReq    (memReq),
    .readData  (readData),
    .flagsE    (flagsE),
    .noWriteE  (noWriteE),
    .match     (match),
    .hazard    (hazard)
  );

  controller iController (
    .clk       (clk),
    .rstN      (rstN),
    .instrD    (instrD),
    .flagsE    (flagsE),
    .noWriteE  (noWriteE),
    .hazard    (hazard),
    .decodeCtrl(decodeCtrl),
    .execCtrl  (execCtrl),
    .memWrite  (memWrite),
    .wbCtrl    (wbCtrl),
    .ctrlState (ctrlState)
  );

  hazardUnit iHazardUnit (
    .match    (match),
    .ctrlState(ctrlState),
    .hazard   (hazard)
  );

endmodule

/* logic/datapath.sv */
`timescale 1ns/100ps

module datapath (
  input  logic               clk,
  input  logic               rstN,
  output armPkg::wordT       pc,
  input  armPkg::wordT       instr,
  output armPkg::instrT      instrD,
  input  armPkg::decodeCtrlT decodeCtrl,
  input  armPkg::execCtrlT   execCtrl,
  input  armPkg::wbCtrlT     wbCtrl,
  input  logic               memWrite,
  output armPkg::memReqT     memReq,
  input  armPkg::wordT       readData,
  output armPkg::flagsT      flagsE,
  output logic               noWriteE,
  output armPkg::matchT      match,
  input  armPkg::hazardT     hazard
);

  typedef struct packed {
    armPkg::wordT    rd1;
    armPkg::wordT    rd2;
    armPkg::wordT    extImm;
    armPkg::regAddrT wa;
    armPkg::regAddrT ra1;
    armPkg::regAddrT ra2;
  } execRegT;

  // data is store data in memory, load data in writeback
  typedef struct packed {
    armPkg::wordT    aluOut;
    armPkg::wordT    data;
    armPkg::regAddrT wa;
  } lateRegT;

  armPkg::wordT    pcPlus4F, pcNextF;
  armPkg::regAddrT ra1D, ra2D;
  armPkg::wordT    rd1D, rd2D, extImmD;
  armPkg::wordT    srcAE, srcBE, writeDataE;
  armPkg::wordT    aluAE, aluBE, aluResultE;
  armPkg::wordT    resultW;
  execRegT         exR;
  lateRegT         memR, wbR;

  function automatic armPkg::wordT bypass(armPkg::fwdSelT sel, armPkg::wordT regVal,
                                          armPkg::wordT result, armPkg::wordT aluOut);
    case (sel)
      armPkg::fwdResult: return result;
      armPkg::fwdAluOut: return aluOut;
      default: return regVal;
    endcase
  endfunction

  assign pcPlus4F = pc + 32'd4;
  assign pcNextF  = execCtrl.branchTaken ? aluResultE : pcPlus4F;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= '0;
      instrD <= '0;
    end else begin
      if (!hazard.stallF) begin
        pc <= pcNextF;
      end
      if (!hazard.stallD) begin
        instrD <= hazard.flushD ? '0 : instr;
      end
    end
  end

  assign ra1D = decodeCtrl.regSrc[0] ? 4'd15 : instrD.dp.rn;
  assign ra2D = decodeCtrl.regSrc[1] ? instrD.mem.rd : instrD.dp.src2[3:0];

  // Fetch PC+4 is PC+8 of the decode instruction
  regFile iRegFile (
    .clk    (clk),
    .we     (wbCtrl.regWrite),
    .ra1    (ra1D),
    .ra2    (ra2D),
    .wa     (wbR.wa),
    .wd     (resultW),
    .pcPlus8(pcPlus4F),
    .rd1    (rd1D),
    .rd2    (rd2D)
  );

  always_comb begin
    case (decodeCtrl.immSrc)
      armPkg::immDp:  extImmD = {24'b0, instrD.dp.src2[7:0]};
      armPkg::immMem: extImmD = {20'b0, instrD.mem.imm12};
      default:        extImmD = {{6{instrD.br.imm24[23]}}, instrD.br.imm24, 2'b00};
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exR  <= '0;
      memR <= '0;
      wbR  <= '0;
    end else begin
      exR  <= '{rd1: rd1D, rd2: rd2D, extImm: extImmD, wa: instrD.dp.rd,
                ra1: ra1D, ra2: ra2D};
      memR <= '{aluOut: aluResultE, data: writeDataE, wa: exR.wa};
      wbR  <= '{aluOut: memR.aluOut, data: readData, wa: memR.wa};
    end
  end

  assign srcAE      = bypass(hazard.forwardA, exR.rd1, resultW, memR.aluOut);
  assign writeDataE = bypass(hazard.forwardB, exR.rd2, resultW, memR.aluOut);
  assign srcBE      = execCtrl.aluSrc ? exR.extImm : writeDataE;
  // RSB runs as SUB on swapped operands
  assign aluAE      = execCtrl.swapInputs ? srcBE : srcAE;
  assign aluBE      = execCtrl.swapInputs ? srcAE : srcBE;

  alu iAlu (
    .a      (aluAE),
    .b      (aluBE),
    .aluOp  (execCtrl.aluOp),
    .carryIn(execCtrl.carryIn),
    .result (aluResultE),
    .flags  (flagsE),
    .noWrite(noWriteE)
  );

  assign memReq  = '{write: memWrite, addr: memR.aluOut, writeData: memR.data};
  assign resultW = wbCtrl.memToReg ? wbR.data : wbR.aluOut;

  assign match.m1EM  = (memR.wa == exR.ra1);
  assign match.m1EW  = (wbR.wa == exR.ra1);
  assign match.m2EM  = (memR.wa == exR.ra2);
  assign match.m2EW  = (wbR.wa == exR.ra2);
  assign match.m12DE = (exR.wa == ra1D) || (exR.wa == ra2D);

  // A fetch stall during a taken branch would lose the redirect
  assert property (@(posedge clk) disable iff (!rstN)
                   !(hazard.stallF && execCtrl.branchTaken))
    else $error("datapath: load-use stall during taken branch");

endmodule

/* logic/hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit (
  input  armPkg::matchT     match,
  input  armPkg::ctrlStateT ctrlState,
  output armPkg::hazardT    hazard
);

  logic loadStall;

  // Memory stage holds the younger value, so it wins
  function automatic armPkg::fwdSelT fwdSel(logic matchM, logic matchW,
                                            armPkg::ctrlStateT st);
    if (matchM && st.regWriteM) begin
      return armPkg::fwdAluOut;
    end else if (matchW && st.regWriteW) begin
      return armPkg::fwdResult;
    end
    return armPkg::fwdRegFile;
  endfunction

  assign hazard.forwardA = fwdSel(match.m1EM, match.m1EW, ctrlState);
  assign hazard.forwardB = fwdSel(match.m2EM, match.m2EW, ctrlState);

  // Load in execute with its user in decode
  assign loadStall = match.m12DE & ctrlState.memToRegE;

  assign hazard.stallF = loadStall;
  assign hazard.stallD = loadStall;
  assign hazard.flushD = ctrlState.branchTakenE;
  assign hazard.flushE = loadStall | ctrlState.branchTakenE;

endmodule

/* logic/controller.sv */
`timescale 1ns/100ps

module controller (
  input  logic               clk,
  input  logic               rstN,
  input  armPkg::instrT      instrD,
  input  armPkg::flagsT      flagsE,
  input  logic               noWriteE,
  input  armPkg::hazardT     hazard,
  output armPkg::decodeCtrlT decodeCtrl,
  output armPkg::execCtrlT   execCtrl,
  output logic               memWrite,
  output armPkg::wbCtrlT     wbCtrl,
  output armPkg::ctrlStateT  ctrlState
);

  typedef struct packed {
    armPkg::condT   cond;
    armPkg::aluOpT  aluOp;
    logic           aluSrc;
    logic           swapInputs;
    logic           flagWrite;
    logic           branch;
    logic           memWrite;
    armPkg::wbCtrlT wb;
  } exCtrlT;

  typedef struct packed {
    logic           memWrite;
    armPkg::wbCtrlT wb;
  } memCtrlT;

  exCtrlT         ctrlD, exR;
  memCtrlT        memR;
  armPkg::wbCtrlT wbR;
  armPkg::flagsT  flags, flagsNext;
  logic           condE;

  function automatic logic condHolds(armPkg::condT cond, armPkg::flagsT f);
    case (cond)
      4'h0: return f.z;
      4'h1: return !f.z;
      4'h2: return f.c;
      4'h3: return !f.c;
      4'h4: return f.n;
      4'h5: return !f.n;
      4'h6: return f.v;
      4'h7: return !f.v;
      4'h8: return f.c && !f.z;
      4'h9: return !f.c || f.z;
      4'ha: return f.n == f.v;
      4'hb: return f.n != f.v;
      4'hc: return !f.z && (f.n == f.v);
      4'hd: return f.z || (f.n != f.v);
      4'he: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  always_comb begin
    ctrlD      = '0;
    ctrlD.cond = instrD.dp.cond;
    decodeCtrl = '{regSrc: 2'b00, immSrc: armPkg::immDp};
    case (instrD.dp.op)
      2'b00: begin
        ctrlD.aluSrc      = instrD.dp.imm;
        ctrlD.flagWrite   = instrD.dp.s;
        ctrlD.wb.regWrite = 1'b1;
        case (instrD.dp.opcode)
          4'b0000: ctrlD.aluOp = armPkg::aluAnd;
          4'b0001: ctrlD.aluOp = armPkg::aluEor;
          4'b0010: ctrlD.aluOp = armPkg::aluSub;
          4'b0011: begin
            ctrlD.aluOp      = armPkg::aluRsb;
            ctrlD.swapInputs = 1'b1;
          end
          4'b0100: ctrlD.aluOp = armPkg::aluAdd;
          4'b0101: ctrlD.aluOp = armPkg::aluAdc;
          4'b1000: ctrlD.aluOp = armPkg::aluTst;
          4'b1010: ctrlD.aluOp = armPkg::aluCmp;
          4'b1100: ctrlD.aluOp = armPkg::aluOrr;
          default: ctrlD = '0;
        endcase
      end
      2'b01: begin
        // Store reads rd through the second port
        decodeCtrl     = '{regSrc: {~instrD.mem.load, 1'b0}, immSrc: armPkg::immMem};
        ctrlD.aluSrc   = 1'b1;
        ctrlD.aluOp    = armPkg::aluAdd;
        ctrlD.memWrite = ~instrD.mem.load;
        ctrlD.wb       = '{regWrite: instrD.mem.load, memToReg: instrD.mem.load};
      end
      2'b10: begin
        decodeCtrl   = '{regSrc: 2'b01, immSrc: armPkg::immBranch};
        ctrlD.aluSrc = 1'b1;
        ctrlD.aluOp  = armPkg::aluAdd;
        ctrlD.branch = 1'b1;
      end
      default: ctrlD = '0;
    endcase
  end

  assign condE = condHolds(exR.cond, flags);

  assign execCtrl = '{aluSrc: exR.aluSrc, aluOp: exR.aluOp, swapInputs: exR.swapInputs,
                      carryIn: flags.c, branchTaken: exR.branch & condE};

  // Logic ops leave V alone
  always_comb begin
    flagsNext = flagsE;
    if (exR.aluOp inside {armPkg::aluAnd, armPkg::aluEor, armPkg::aluOrr, armPkg::aluTst}) begin
      flagsNext.v = flags.v;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exR   <= '0;
      memR  <= '0;
      wbR   <= '0;
      flags <= '0;
    end else begin
      if (hazard.flushE) begin
        exR <= '0;
      end else begin
        exR <= ctrlD;
      end
      memR.memWrite    <= exR.memWrite & condE;
      memR.wb.regWrite <= exR.wb.regWrite & condE & ~noWriteE;
      memR.wb.memToReg <= exR.wb.memToReg;
      wbR              <= memR.wb;
      if (exR.flagWrite && condE) begin
        flags <= flagsNext;
      end
    end
  end

  assign memWrite  = memR.memWrite;
  assign wbCtrl    = wbR;
  assign ctrlState = '{regWriteM: memR.wb.regWrite, regWriteW: wbR.regWrite,
                       memToRegE: exR.wb.memToReg, branchTakenE: execCtrl.branchTaken};

endmodule

/* logic/regFile.sv */
`timescale 1ns/100ps

module regFile (
  input  logic            clk,
  input  logic            we,
  input  armPkg::regAddrT ra1,
  input  armPkg::regAddrT ra2,
  input  armPkg::regAddrT wa,
  input  armPkg::wordT    wd,
  input  armPkg::wordT    pcPlus8,
  output armPkg::wordT    rd1,
  output armPkg::wordT    rd2
);

  armPkg::wordT regs [0:14];

  // Falling edge write, so decode sees writeback in the same cycle
  always_ff @(negedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == 4'd15) ? pcPlus8 : regs[ra1];
  assign rd2 = (ra2 == 4'd15) ? pcPlus8 : regs[ra2];

  // r15 is the PC and is never a writeback target
  assert property (@(negedge clk) we |-> wa != 4'd15)
    else $error("regFile: write to r15");

endmodule

/* logic/alu.sv */
`timescale 1ns/100ps

module alu (
  input  armPkg::wordT  a,
  input  armPkg::wordT  b,
  input  armPkg::aluOpT aluOp,
  input  logic          carryIn,
  output armPkg::wordT  result,
  output armPkg::flagsT flags,
  output logic          noWrite
);

  logic         subtract;
  logic         arith;
  logic         cin;
  armPkg::wordT bOp;
  logic [32:0]  sum;

  // Subtract is a plus inverted b plus one
  assign subtract = aluOp inside {armPkg::aluSub, armPkg::aluRsb, armPkg::aluCmp};
  assign cin      = subtract | (aluOp == armPkg::aluAdc && carryIn);
  assign bOp      = subtract ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, bOp} + {32'b0, cin};

  always_comb begin
    result  = sum[31:0];
    arith   = 1'b1;
    noWrite = 1'b0;
    case (aluOp)
      armPkg::aluAnd: begin
        result = a & b;
        arith  = 1'b0;
      end
      armPkg::aluEor: begin
        result = a ^ b;
        arith  = 1'b0;
      end
      armPkg::aluOrr: begin
        result = a | b;
        arith  = 1'b0;
      end
      armPkg::aluTst: begin
        result  = a & b;
        arith   = 1'b0;
        noWrite = 1'b1;
      end
      armPkg::aluCmp: noWrite = 1'b1;
      default: result = sum[31:0];
    endcase
  end

  assign flags.n = result[31];
  assign flags.z = (result == '0);
  // Logic ops keep the incoming carry
  assign flags.c = arith ? sum[32] : carryIn;
  assign flags.v = arith & (a[31] == bOp[31]) & (sum[31] != a[31]);

endmodule

/* logic/armPkg.sv */
package armPkg;

  typedef logic [31:0] wordT;
  typedef logic [3:0]  regAddrT;
  typedef logic [3:0]  condT;

  typedef enum logic [3:0] {
    aluAnd, aluEor, aluSub, aluRsb, aluAdd, aluAdc, aluOrr, aluTst, aluCmp
  } aluOpT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // No shifter, so src2 is imm8 in [7:0] or rm in [3:0]
  typedef struct packed {
    condT        cond;
    logic [1:0]  op;
    logic        imm;
    logic [3:0]  opcode;
    logic        s;
    regAddrT     rn;
    regAddrT     rd;
    logic [11:0] src2;
  } dpInstrT;

  typedef struct packed {
    condT        cond;
    logic [1:0]  op;
    logic [4:0]  mode;
    logic        load;
    regAddrT     rn;
    regAddrT     rd;
    logic [11:0] imm12;
  } memInstrT;

  typedef struct packed {
    condT        cond;
    logic [1:0]  op;
    logic [1:0]  funct;
    logic [23:0] imm24;
  } brInstrT;

  typedef union packed {
    dpInstrT  dp;
    memInstrT mem;
    brInstrT  br;
  } instrT;

  typedef enum logic [1:0] {immDp, immMem, immBranch} immSrcT;

  typedef struct packed {
    logic [1:0] regSrc;
    immSrcT     immSrc;
  } decodeCtrlT;

  typedef struct packed {
    logic  aluSrc;
    aluOpT aluOp;
    logic  swapInputs;
    logic  carryIn;
    logic  branchTaken;
  } execCtrlT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
  } wbCtrlT;

  typedef struct packed {
    logic m1EM;
    logic m1EW;
    logic m2EM;
    logic m2EW;
    logic m12DE;
  } matchT;

  typedef enum logic [1:0] {fwdRegFile, fwdResult, fwdAluOut} fwdSelT;

  typedef struct packed {
    fwdSelT forwardA;
    fwdSelT forwardB;
    logic   stallF;
    logic   stallD;
    logic   flushD;
    logic   flushE;
  } hazardT;

  typedef struct packed {
    logic write;
    wordT addr;
    wordT writeData;
  } memReqT;

  typedef struct packed {
    logic regWriteM;
    logic regWriteW;
    logic memToRegE;
    logic branchTakenE;
  } ctrlStateT;

endpackage
